//--- hw/issue_pkg.sv
// ==========================================================
// issue stage package
// widths, payload field types and lane count shared by the
// issue stage blocks and the testbench
// ==========================================================
`default_nettype none

package issue_pkg;

    // field widths
    localparam int INST_ADDR_W = 32;
    localparam int INST_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMM_W       = 32;
    localparam int COMMIT_ID_W = 4;

    // two issue lanes per cycle
    localparam int NUM_LANES = 2;

    // payload field types
    typedef logic [INST_ADDR_W-1:0] inst_addr_t;
    typedef logic [INST_W-1:0]      inst_word_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [IMM_W-1:0]       imm_t;
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;

    // bit n belongs to lane n+1
    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // address zero marks an empty slot from the decoder
    localparam inst_addr_t ADDR_NONE = '0;

endpackage

`default_nettype wire

//--- hw/issue_dup_filter.sv
// ==========================================================
// issue duplicate filter
// remembers the last accepted address per lane and decides
// which lanes are killed in the current cycle
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module issue_dup_filter import issue_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // decoder side
    input  lane_mask_t issue_i,
    input  inst_addr_t inst1_addr_i,
    input  inst_addr_t inst2_addr_i,

    // control
    input  logic       flush_i,
    input  logic       irq_req_i,
    input  logic       out_ready_i,

    // kill decision
    output lane_mask_t lane_kill_o,
    output lane_mask_t already_issued_o
);

    inst_addr_t cur_addr  [NUM_LANES];
    inst_addr_t hist_addr [NUM_LANES];
    lane_mask_t hist_issued;
    lane_mask_t dup_hit;
    logic       kill_all;

    assign cur_addr[0] = inst1_addr_i;
    assign cur_addr[1] = inst2_addr_i;

    // decoder keeps presenting the same instruction until it moves on,
    // so a match against an issued history entry means it already went out
    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            dup_hit[n] = hist_issued[n]
                      && (cur_addr[n] == hist_addr[n])
                      && (cur_addr[n] != ADDR_NONE);
        end
    end

    // flush and pending interrupt drop both lanes
    assign kill_all = flush_i | irq_req_i;

    assign lane_kill_o      = {NUM_LANES{kill_all}} | ~issue_i | dup_hit;
    assign already_issued_o = dup_hit;

    // issue history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_issued <= '0;
            for (int n = 0; n < NUM_LANES; n++) begin
                hist_addr[n] <= ADDR_NONE;
            end
        end else if (flush_i) begin
            hist_issued <= '0;
            for (int n = 0; n < NUM_LANES; n++) begin
                hist_addr[n] <= ADDR_NONE;
            end
        end else if (out_ready_i) begin
            // only advance when dispatch takes the stage contents
            hist_issued <= issue_i;
            for (int n = 0; n < NUM_LANES; n++) begin
                hist_addr[n] <= cur_addr[n];
            end
        end
    end

    // flush kills both lanes in the same cycle
    a_flush_kills_all: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush_i |-> (lane_kill_o == {NUM_LANES{1'b1}})
    );

endmodule

`default_nettype wire

//--- hw/issue_lane_reg.sv
// ==========================================================
// issue lane register
// one lane's payload toward dispatch, zeroed on kill, held
// under back-pressure, plus the commit id redirect report
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module issue_lane_reg import issue_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // control
    input  logic       load_i,
    input  logic       kill_i,
    input  logic       redirect_i,

    // lane payload from decoder
    input  inst_addr_t addr_i,
    input  inst_word_t word_i,
    input  logic       rd_we_i,
    input  reg_addr_t  rd_addr_i,
    input  reg_addr_t  rs1_addr_i,
    input  reg_addr_t  rs2_addr_i,
    input  imm_t       imm_i,
    input  logic       illegal_i,
    input  commit_id_t commit_id_i,

    // registered lane toward dispatch
    output logic       valid_o,
    output inst_addr_t addr_o,
    output inst_word_t word_o,
    output logic       rd_we_o,
    output reg_addr_t  rd_addr_o,
    output reg_addr_t  rs1_addr_o,
    output reg_addr_t  rs2_addr_o,
    output imm_t       imm_o,
    output logic       illegal_o,
    output commit_id_t commit_id_o,

    // redirect report
    output commit_id_t squash_commit_id_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o     <= 1'b0;
            addr_o      <= ADDR_NONE;
            word_o      <= '0;
            rd_we_o     <= 1'b0;
            rd_addr_o   <= '0;
            rs1_addr_o  <= '0;
            rs2_addr_o  <= '0;
            imm_o       <= '0;
            illegal_o   <= 1'b0;
            commit_id_o <= '0;
        end else if (load_i) begin
            if (kill_i) begin
                // killed slot goes out as a bubble
                valid_o     <= 1'b0;
                addr_o      <= ADDR_NONE;
                word_o      <= '0;
                rd_we_o     <= 1'b0;
                rd_addr_o   <= '0;
                rs1_addr_o  <= '0;
                rs2_addr_o  <= '0;
                imm_o       <= '0;
                illegal_o   <= 1'b0;
                commit_id_o <= '0;
            end else begin
                valid_o     <= 1'b1;
                addr_o      <= addr_i;
                word_o      <= word_i;
                rd_we_o     <= rd_we_i;
                rd_addr_o   <= rd_addr_i;
                rs1_addr_o  <= rs1_addr_i;
                rs2_addr_o  <= rs2_addr_i;
                imm_o       <= imm_i;
                illegal_o   <= illegal_i;
                commit_id_o <= commit_id_i;
            end
        end
    end

    // held id goes to commit on jump or interrupt, valid or not
    assign squash_commit_id_o = redirect_i ? commit_id_o : '0;

    // dispatch sees a stable lane until it is taken
    a_hold_when_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_o && !load_i) |=> ($stable(valid_o) && $stable(addr_o)
            && $stable(word_o) && $stable(rd_we_o) && $stable(rd_addr_o)
            && $stable(rs1_addr_o) && $stable(rs2_addr_o) && $stable(imm_o)
            && $stable(illegal_o) && $stable(commit_id_o))
    );

    // an empty slot carries no stale payload
    a_bubble_is_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !valid_o |-> (addr_o == ADDR_NONE && word_o == '0 && !rd_we_o
            && rd_addr_o == '0 && rs1_addr_o == '0 && rs2_addr_o == '0
            && imm_o == '0 && !illegal_o && commit_id_o == '0)
    );

endmodule

`default_nettype wire

//--- hw/issue_stage.sv
// ==========================================================
// issue stage
// dual-issue stage register between decode and dispatch
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module issue_stage import issue_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // decoder, lane 1
    input  lane_mask_t issue_i,
    input  inst_addr_t inst1_addr_i,
    input  inst_word_t inst1_word_i,
    input  logic       inst1_rd_we_i,
    input  reg_addr_t  inst1_rd_addr_i,
    input  reg_addr_t  inst1_rs1_addr_i,
    input  reg_addr_t  inst1_rs2_addr_i,
    input  imm_t       inst1_imm_i,
    input  logic       inst1_illegal_i,
    input  commit_id_t inst1_commit_id_i,

    // decoder, lane 2
    input  inst_addr_t inst2_addr_i,
    input  inst_word_t inst2_word_i,
    input  logic       inst2_rd_we_i,
    input  reg_addr_t  inst2_rd_addr_i,
    input  reg_addr_t  inst2_rs1_addr_i,
    input  reg_addr_t  inst2_rs2_addr_i,
    input  imm_t       inst2_imm_i,
    input  logic       inst2_illegal_i,
    input  commit_id_t inst2_commit_id_i,

    // control
    input  logic       flush_i,
    input  logic       irq_req_i,
    input  logic       jump_i,

    // dispatch, lane 1
    output logic       inst1_valid_o,
    output inst_addr_t inst1_addr_o,
    output inst_word_t inst1_word_o,
    output logic       inst1_rd_we_o,
    output reg_addr_t  inst1_rd_addr_o,
    output reg_addr_t  inst1_rs1_addr_o,
    output reg_addr_t  inst1_rs2_addr_o,
    output imm_t       inst1_imm_o,
    output logic       inst1_illegal_o,
    output commit_id_t inst1_commit_id_o,

    // dispatch, lane 2
    output logic       inst2_valid_o,
    output inst_addr_t inst2_addr_o,
    output inst_word_t inst2_word_o,
    output logic       inst2_rd_we_o,
    output reg_addr_t  inst2_rd_addr_o,
    output reg_addr_t  inst2_rs1_addr_o,
    output reg_addr_t  inst2_rs2_addr_o,
    output imm_t       inst2_imm_o,
    output logic       inst2_illegal_o,
    output commit_id_t inst2_commit_id_o,
    input  logic       out_ready_i,

    // status and redirect report
    output lane_mask_t already_issued_o,
    output logic       squash_valid_o,
    output commit_id_t squash_1_commit_id_o,
    output commit_id_t squash_2_commit_id_o
);

    lane_mask_t lane_kill;
    logic       redirect;

    assign redirect       = jump_i | irq_req_i;
    assign squash_valid_o = redirect;

    issue_dup_filter u_dup_filter (
        .clk              (clk),
        .rst_n            (rst_n),
        .issue_i          (issue_i),
        .inst1_addr_i     (inst1_addr_i),
        .inst2_addr_i     (inst2_addr_i),
        .flush_i          (flush_i),
        .irq_req_i        (irq_req_i),
        .out_ready_i      (out_ready_i),
        .lane_kill_o      (lane_kill),
        .already_issued_o (already_issued_o)
    );

    issue_lane_reg u_lane1 (
        .clk                (clk),
        .rst_n              (rst_n),
        .load_i             (out_ready_i),
        .kill_i             (lane_kill[0]),
        .redirect_i         (redirect),
        .addr_i             (inst1_addr_i),
        .word_i             (inst1_word_i),
        .rd_we_i            (inst1_rd_we_i),
        .rd_addr_i          (inst1_rd_addr_i),
        .rs1_addr_i         (inst1_rs1_addr_i),
        .rs2_addr_i         (inst1_rs2_addr_i),
        .imm_i              (inst1_imm_i),
        .illegal_i          (inst1_illegal_i),
        .commit_id_i        (inst1_commit_id_i),
        .valid_o            (inst1_valid_o),
        .addr_o             (inst1_addr_o),
        .word_o             (inst1_word_o),
        .rd_we_o            (inst1_rd_we_o),
        .rd_addr_o          (inst1_rd_addr_o),
        .rs1_addr_o         (inst1_rs1_addr_o),
        .rs2_addr_o         (inst1_rs2_addr_o),
        .imm_o              (inst1_imm_o),
        .illegal_o          (inst1_illegal_o),
        .commit_id_o        (inst1_commit_id_o),
        .squash_commit_id_o (squash_1_commit_id_o)
    );

    issue_lane_reg u_lane2 (
        .clk                (clk),
        .rst_n              (rst_n),
        .load_i             (out_ready_i),
        .kill_i             (lane_kill[1]),
        .redirect_i         (redirect),
        .addr_i             (inst2_addr_i),
        .word_i             (inst2_word_i),
        .rd_we_i            (inst2_rd_we_i),
        .rd_addr_i          (inst2_rd_addr_i),
        .rs1_addr_i         (inst2_rs1_addr_i),
        .rs2_addr_i         (inst2_rs2_addr_i),
        .imm_i              (inst2_imm_i),
        .illegal_i          (inst2_illegal_i),
        .commit_id_i        (inst2_commit_id_i),
        .valid_o            (inst2_valid_o),
        .addr_o             (inst2_addr_o),
        .word_o             (inst2_word_o),
        .rd_we_o            (inst2_rd_we_o),
        .rd_addr_o          (inst2_rd_addr_o),
        .rs1_addr_o         (inst2_rs1_addr_o),
        .rs2_addr_o         (inst2_rs2_addr_o),
        .imm_o              (inst2_imm_o),
        .illegal_o          (inst2_illegal_o),
        .commit_id_o        (inst2_commit_id_o),
        .squash_commit_id_o (squash_2_commit_id_o)
    );

endmodule

`default_nettype wire

//--- include/issue_tb_tasks.svh
// ==========================================================
// issue stage testbench compare tasks and pass/fail counters
// ==========================================================
`ifndef ISSUE_TB_TASKS_SVH
`define ISSUE_TB_TASKS_SVH

int pass_cnt = 0;
int fail_cnt = 0;

task automatic check_valid(input issue_pkg::lane_mask_t got, input issue_pkg::lane_mask_t exp,
                           input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic check_addr(input issue_pkg::inst_addr_t got, input issue_pkg::inst_addr_t exp,
                          input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic check_reg(input issue_pkg::reg_addr_t got, input issue_pkg::reg_addr_t exp,
                         input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

// serves the instruction word and the immediate, both 32 bits
task automatic check_word(input issue_pkg::inst_word_t got, input issue_pkg::inst_word_t exp,
                          input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

task automatic check_id(input issue_pkg::commit_id_t got, input issue_pkg::commit_id_t exp,
                        input string msg);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, msg, got, exp);
        fail_cnt++;
    end else begin
        pass_cnt++;
    end
endtask

`endif

//--- verif/tb_issue_stage.sv
// ==========================================================
// issue stage testbench
// random and directed lane traffic checked every cycle
// against a reference model of the kill and history rules
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage import issue_pkg::*; ();

    `include "issue_tb_tasks.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int PLAIN_N      = 24;
    localparam int STALL_N      = 5;
    localparam int REDIR_N      = 8;
    // directed steps, drain cycles and reset release on top of the loops
    localparam int FIXED_CYCLES = 20;
    localparam int TOTAL_CYCLES = RESET_CYCLES + PLAIN_N + STALL_N + REDIR_N + FIXED_CYCLES;
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * CLK_PERIOD;

    typedef struct packed {
        inst_addr_t addr;
        inst_word_t word;
        logic       rd_we;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        imm_t       imm;
        logic       illegal;
        commit_id_t cid;
    } payload_t;

    typedef struct packed {
        logic     valid;
        payload_t pl;
    } lane_out_t;

    logic       clk;
    logic       rst_n;
    lane_mask_t issue;
    payload_t   in1;
    payload_t   in2;
    logic       flush;
    logic       irq_req;
    logic       jump;
    logic       out_ready;

    logic       o1_valid;
    logic       o2_valid;
    payload_t   got1;
    payload_t   got2;
    inst_addr_t o1_addr, o2_addr;
    inst_word_t o1_word, o2_word;
    logic       o1_rd_we, o2_rd_we;
    reg_addr_t  o1_rd, o2_rd, o1_rs1, o2_rs1, o1_rs2, o2_rs2;
    imm_t       o1_imm, o2_imm;
    logic       o1_illegal, o2_illegal;
    commit_id_t o1_cid, o2_cid;
    lane_mask_t already_issued;
    logic       squash_valid;
    commit_id_t squash1_id, squash2_id;

    integer     seed = 2;
    int         test_fail_base = 0;

    // reference state
    lane_out_t  exp1 = '0;
    lane_out_t  exp2 = '0;
    inst_addr_t mdl_addr [NUM_LANES] = '{default: '0};
    lane_mask_t mdl_issued = '0;

    assign got1 = {o1_addr, o1_word, o1_rd_we, o1_rd, o1_rs1, o1_rs2, o1_imm, o1_illegal, o1_cid};
    assign got2 = {o2_addr, o2_word, o2_rd_we, o2_rd, o2_rs1, o2_rs2, o2_imm, o2_illegal, o2_cid};

    issue_stage u_issue_stage (
        .clk                  (clk),
        .rst_n                (rst_n),
        .issue_i              (issue),
        .inst1_addr_i         (in1.addr),
        .inst1_word_i         (in1.word),
        .inst1_rd_we_i        (in1.rd_we),
        .inst1_rd_addr_i      (in1.rd),
        .inst1_rs1_addr_i     (in1.rs1),
        .inst1_rs2_addr_i     (in1.rs2),
        .inst1_imm_i          (in1.imm),
        .inst1_illegal_i      (in1.illegal),
        .inst1_commit_id_i    (in1.cid),
        .inst2_addr_i         (in2.addr),
        .inst2_word_i         (in2.word),
        .inst2_rd_we_i        (in2.rd_we),
        .inst2_rd_addr_i      (in2.rd),
        .inst2_rs1_addr_i     (in2.rs1),
        .inst2_rs2_addr_i     (in2.rs2),
        .inst2_imm_i          (in2.imm),
        .inst2_illegal_i      (in2.illegal),
        .inst2_commit_id_i    (in2.cid),
        .flush_i              (flush),
        .irq_req_i            (irq_req),
        .jump_i               (jump),
        .inst1_valid_o        (o1_valid),
        .inst1_addr_o         (o1_addr),
        .inst1_word_o         (o1_word),
        .inst1_rd_we_o        (o1_rd_we),
        .inst1_rd_addr_o      (o1_rd),
        .inst1_rs1_addr_o     (o1_rs1),
        .inst1_rs2_addr_o     (o1_rs2),
        .inst1_imm_o          (o1_imm),
        .inst1_illegal_o      (o1_illegal),
        .inst1_commit_id_o    (o1_cid),
        .inst2_valid_o        (o2_valid),
        .inst2_addr_o         (o2_addr),
        .inst2_word_o         (o2_word),
        .inst2_rd_we_o        (o2_rd_we),
        .inst2_rd_addr_o      (o2_rd),
        .inst2_rs1_addr_o     (o2_rs1),
        .inst2_rs2_addr_o     (o2_rs2),
        .inst2_imm_o          (o2_imm),
        .inst2_illegal_o      (o2_illegal),
        .inst2_commit_id_o    (o2_cid),
        .out_ready_i          (out_ready),
        .already_issued_o     (already_issued),
        .squash_valid_o       (squash_valid),
        .squash_1_commit_id_o (squash1_id),
        .squash_2_commit_id_o (squash2_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // lane n counts as issued if the history holds its address
    function automatic logic is_dup(input int n, input inst_addr_t a);
        return mdl_issued[n] && (a == mdl_addr[n]) && (a != ADDR_NONE);
    endfunction

    // next register value of lane n at this edge, history advances too
    function automatic lane_out_t ref_lane(input int n, input payload_t p, input lane_out_t cur);
        lane_out_t nxt;
        logic      kill;
        nxt  = cur;
        kill = flush || irq_req || !issue[n] || is_dup(n, p.addr);
        if (out_ready) begin
            if (kill) begin
                nxt = '0;
            end else begin
                nxt.valid = 1'b1;
                nxt.pl    = p;
            end
        end
        if (flush) begin
            mdl_addr[n]   = ADDR_NONE;
            mdl_issued[n] = 1'b0;
        end else if (out_ready) begin
            mdl_addr[n]   = p.addr;
            mdl_issued[n] = issue[n];
        end
        return nxt;
    endfunction

    task automatic compare_lane(input string tag, input lane_out_t e, input payload_t g);
        check_addr(g.addr, e.pl.addr, {tag, " addr"});
        check_word(g.word, e.pl.word, {tag, " word"});
        check_valid({g.rd_we, g.illegal}, {e.pl.rd_we, e.pl.illegal}, {tag, " rd_we/illegal"});
        check_reg(g.rd, e.pl.rd, {tag, " rd"});
        check_reg(g.rs1, e.pl.rs1, {tag, " rs1"});
        check_reg(g.rs2, e.pl.rs2, {tag, " rs2"});
        check_word(g.imm, e.pl.imm, {tag, " imm"});
        check_id(g.cid, e.pl.cid, {tag, " commit id"});
    endtask

    // combinational outputs at the falling edge, registers just after the rising edge
    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            check_valid(already_issued, {is_dup(1, in2.addr), is_dup(0, in1.addr)},
                        "already_issued_o");
            check_valid({1'b0, squash_valid}, {1'b0, jump | irq_req}, "squash_valid_o");
            check_id(squash1_id, (jump | irq_req) ? exp1.pl.cid : commit_id_t'(0),
                     "squash_1_commit_id_o");
            check_id(squash2_id, (jump | irq_req) ? exp2.pl.cid : commit_id_t'(0),
                     "squash_2_commit_id_o");
            @(posedge clk);
            exp1 = ref_lane(0, in1, exp1);
            exp2 = ref_lane(1, in2, exp2);
            #1;
            check_valid({o2_valid, o1_valid}, {exp2.valid, exp1.valid}, "valid");
            compare_lane("lane 1", exp1, got1);
            compare_lane("lane 2", exp2, got2);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic payload_t rand_payload(input inst_addr_t a);
        payload_t p;
        p.addr    = a;
        p.word    = $random(seed);
        p.rd_we   = $random(seed);
        p.rd      = $random(seed);
        p.rs1     = $random(seed);
        p.rs2     = $random(seed);
        p.imm     = $random(seed);
        p.illegal = $random(seed);
        p.cid     = $random(seed);
        return p;
    endfunction

    task automatic present(input lane_mask_t iss, input inst_addr_t a1, input inst_addr_t a2);
        issue = iss;
        in1   = rand_payload(a1);
        in2   = rand_payload(a2);
    endtask

    task automatic expect_dup(input lane_mask_t m, input string what);
        @(negedge clk);
        check_valid(already_issued, m, what);
    endtask

    task automatic finish_test(input string name);
        next_cycle();
        $display("test %-12s done, %0d mismatches", name, fail_cnt - test_fail_base);
        test_fail_base = fail_cnt;
    endtask

    initial begin
        rst_n     = 1'b0;
        issue     = '0;
        in1       = '0;
        in2       = '0;
        flush     = 1'b0;
        irq_req   = 1'b0;
        jump      = 1'b0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n     = 1'b1;
        out_ready = 1'b1;

        // new addresses every cycle, a lane dropped now and then
        for (int i = 0; i < PLAIN_N; i++) begin
            present((i % 6 == 5) ? 2'b01 : ((i % 6 == 4) ? 2'b10 : 2'b11),
                    32'h1000 + i * 8, 32'h1004 + i * 8);
            next_cycle();
        end
        finish_test("plain_issue");

        present(2'b11, 32'h2000, 32'h2004);
        next_cycle();
        expect_dup(2'b11, "repeat of issued pair");
        next_cycle();
        check_valid({o2_valid, o1_valid}, 2'b00, "duplicate pair killed");
        // address zero never counts as issued
        present(2'b11, ADDR_NONE, ADDR_NONE);
        next_cycle();
        expect_dup(2'b00, "address zero repeated");
        next_cycle();
        check_valid({o2_valid, o1_valid}, 2'b11, "address zero issues again");
        finish_test("duplicate");

        present(2'b11, 32'h3000, 32'h3004);
        next_cycle();
        out_ready = 1'b0;
        for (int i = 0; i < STALL_N; i++) begin
            present(2'b11, 32'h3100 + i * 8, 32'h3104 + i * 8);
            next_cycle();
        end
        check_addr(o1_addr, 32'h3000, "lane 1 held under stall");
        check_addr(o2_addr, 32'h3004, "lane 2 held under stall");
        out_ready = 1'b1;
        present(2'b11, 32'h3000, 32'h3004);
        expect_dup(2'b11, "history kept across stall");
        next_cycle();
        finish_test("backpressure");

        present(2'b11, 32'h4000, 32'h4004);
        next_cycle();
        // fresh pair under flush, so only the flush can kill it
        flush = 1'b1;
        present(2'b11, 32'h4010, 32'h4014);
        next_cycle();
        flush = 1'b0;
        check_valid({o2_valid, o1_valid}, 2'b00, "flush kills both lanes");
        expect_dup(2'b00, "history cleared by flush");
        next_cycle();
        check_valid({o2_valid, o1_valid}, 2'b11, "reissue after flush");
        irq_req = 1'b1;
        present(2'b11, 32'h4100, 32'h4104);
        next_cycle();
        irq_req = 1'b0;
        check_valid({o2_valid, o1_valid}, 2'b00, "interrupt kills both lanes");
        present(2'b11, 32'h4200, 32'h4204);
        next_cycle();
        finish_test("flush_irq");

        // jumps on alternate cycles, some of them during a stall
        for (int i = 0; i < REDIR_N; i++) begin
            present(2'b11, 32'h5000 + i * 8, 32'h5004 + i * 8);
            jump      = (i % 2 == 0);
            out_ready = (i % 3 != 2);
            next_cycle();
        end
        jump      = 1'b0;
        out_ready = 1'b1;
        finish_test("redirect");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hw/issue_pkg.sv
hw/issue_dup_filter.sv
hw/issue_lane_reg.sv
hw/issue_stage.sv
verif/tb_issue_stage.sv
